/* hdl/vchess_pkg.sv */
`default_nettype none

package vchess_pkg;

   localparam int NUM_SQUARES = 64;            // 8 x 8 board
   localparam int EVAL_WIDTH  = 16;            // Signed material width

   // Piece code: bit 3 is colour, bits 2..0 the kind
   typedef logic [3:0] piece_t;
   typedef logic [5:0] square_t;               // rank * 8 + file, a1 = 0
   typedef logic [NUM_SQUARES-1:0] bitboard_t; // Bit n is square n
   typedef logic signed [EVAL_WIDTH-1:0] eval_t;

   localparam piece_t PIECE_EMPTY  = 4'd0;
   localparam piece_t PIECE_PAWN   = 4'd1;
   localparam piece_t PIECE_KNIGHT = 4'd2;
   localparam piece_t PIECE_BISHOP = 4'd3;
   localparam piece_t PIECE_ROOK   = 4'd4;
   localparam piece_t PIECE_QUEEN  = 4'd5;
   localparam piece_t PIECE_KING   = 4'd6;
   localparam piece_t PIECE_BLACK  = 4'd8;     // Colour flag, OR into kind

   localparam square_t SQ_LAST = 6'd63;        // h8, last square of a scan

   // Material in centipawns, king carries no value
   localparam eval_t VAL_PAWN   = 16'sd100;
   localparam eval_t VAL_KNIGHT = 16'sd300;
   localparam eval_t VAL_BISHOP = 16'sd300;
   localparam eval_t VAL_ROOK   = 16'sd500;
   localparam eval_t VAL_QUEEN  = 16'sd900;

   typedef logic [1:0] cmd_op_t;

   localparam cmd_op_t CMD_CLEAR = 2'd0;       // Empty every square
   localparam cmd_op_t CMD_SET   = 2'd1;       // Write one square
   localparam cmd_op_t CMD_EVAL  = 2'd2;       // Scan and report
   // op 3 is a no-op that still returns its credit

   typedef struct packed {
      cmd_op_t op;
      square_t square;
      piece_t  piece;
   } cmd_t;

   typedef struct packed {
      bitboard_t white_attacks;
      bitboard_t black_attacks;
      logic      white_in_check;
      logic      black_in_check;
      eval_t     eval;
   } result_t;

   localparam int CMD_DEPTH     = 2;           // Queue slots = host credits
   localparam int RES_CREDITS   = 2;           // Result credits held at reset
   localparam int CMD_PTR_WIDTH = $clog2(CMD_DEPTH);
   localparam int CMD_CNT_WIDTH = $clog2(CMD_DEPTH + 1);
   localparam int RES_CNT_WIDTH = $clog2(RES_CREDITS + 1);

   typedef enum logic [1:0] {
      IDLE,                                    // Pop and execute commands
      SCAN,                                    // One square per cycle, then settle
      SEND                                     // Hold result until a credit exists
   } ctrl_state_t;

endpackage

`default_nettype wire

/* hdl/board_store.sv */
`timescale 1ns/100ps
`default_nettype none

module board_store (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                clear,
   input  logic                wr_en,
   input  vchess_pkg::square_t wr_square,
   input  vchess_pkg::piece_t  wr_piece,
   input  vchess_pkg::square_t scan_square,
   output vchess_pkg::piece_t  rd_piece
);

   import vchess_pkg::*;

   piece_t board [NUM_SQUARES];                // One piece code per square

   // Contents survive reset, host sends CMD_CLEAR
   always_ff @(posedge clk)
   begin
      if (rst_n)                               // Writes held off while in reset
      begin
         if (clear)
         begin
            for (int sq = 0; sq < NUM_SQUARES; sq++)
            begin
               board[sq] <= PIECE_EMPTY;       // Whole board emptied in one edge
            end
         end
         else if (wr_en)
         begin
            board[wr_square] <= wr_piece;      // Single square update
         end
      end
   end

   // Read port feeds the scan path, no register stage
   assign rd_piece = board[scan_square];

endmodule

`default_nettype wire

/* hdl/attack_map.sv */
`timescale 1ns/100ps
`default_nettype none

module attack_map (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  scan_valid,
   input  logic                  scan_first,
   input  vchess_pkg::square_t   scan_square,
   input  vchess_pkg::piece_t    rd_piece,
   output vchess_pkg::bitboard_t white_attacks,
   output vchess_pkg::bitboard_t black_attacks,
   output logic                  white_in_check,
   output logic                  black_in_check
);

   import vchess_pkg::*;

   piece_t    kind;                            // Piece code with colour stripped
   logic      is_black;
   int        fwd;                             // Pawn direction in ranks
   bitboard_t tgt;                             // Squares hit from scan_square
   bitboard_t king_bit;                        // scan_square if a king sits there
   bitboard_t white_add;
   bitboard_t black_add;
   bitboard_t white_kings;                     // All white king squares seen
   bitboard_t black_kings;

   // One target square, or nothing when it falls off the board
   function automatic bitboard_t step_mask(square_t sq, int dr, int df);
      int        r;
      int        f;
      bitboard_t m;
      r = int'(sq[5:3]) + dr;                  // Rank of target
      f = int'(sq[2:0]) + df;                  // File of target, no wraparound
      m = '0;
      if (r >= 0 && r < 8 && f >= 0 && f < 8)
      begin
         m[r * 8 + f] = 1'b1;
      end
      return m;
   endfunction

   assign kind     = rd_piece & ~PIECE_BLACK;
   assign is_black = |(rd_piece & PIECE_BLACK);
   assign fwd      = is_black ? -1 : 1;        // White moves up the ranks

   always_comb
   begin
      tgt = '0;
      case (kind)
         PIECE_PAWN:
         begin
            tgt = step_mask(scan_square, fwd, -1) |
                  step_mask(scan_square, fwd, 1);   // Diagonal captures only
         end
         PIECE_KNIGHT:
         begin
            tgt = step_mask(scan_square, 1, 2)   | step_mask(scan_square, 2, 1)  |
                  step_mask(scan_square, 2, -1)  | step_mask(scan_square, 1, -2) |
                  step_mask(scan_square, -1, -2) | step_mask(scan_square, -2, -1) |
                  step_mask(scan_square, -2, 1)  | step_mask(scan_square, -1, 2);
         end
         PIECE_KING:
         begin
            for (int dr = -1; dr <= 1; dr++)
            begin
               for (int df = -1; df <= 1; df++)
               begin
                  if (dr != 0 || df != 0)
                  begin
                     tgt = tgt | step_mask(scan_square, dr, df);
                  end
               end
            end
         end
         default:
         begin
            tgt = '0;                          // Empty and sliders attack nothing
         end
      endcase
   end

   assign king_bit  = (kind == PIECE_KING) ? (bitboard_t'(1) << scan_square) : '0;
   assign white_add = is_black ? '0 : tgt;
   assign black_add = is_black ? tgt : '0;

   // scan_first drops the previous board's masks
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         white_attacks <= '0;
         black_attacks <= '0;
         white_kings   <= '0;
         black_kings   <= '0;
      end
      else if (scan_valid)
      begin
         white_attacks <= (scan_first ? '0 : white_attacks) | white_add;
         black_attacks <= (scan_first ? '0 : black_attacks) | black_add;
         white_kings   <= (scan_first ? '0 : white_kings) | (is_black ? '0 : king_bit);
         black_kings   <= (scan_first ? '0 : black_kings) | (is_black ? king_bit : '0);
      end
   end

   // Valid once the last square has folded in
   assign white_in_check = |(white_kings & black_attacks);
   assign black_in_check = |(black_kings & white_attacks);

endmodule

`default_nettype wire

/* hdl/material_eval.sv */
`timescale 1ns/100ps
`default_nettype none

module material_eval (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               scan_valid,
   input  logic               scan_first,
   input  vchess_pkg::piece_t rd_piece,
   output vchess_pkg::eval_t  eval
);

   import vchess_pkg::*;

   eval_t value;                               // Unsigned worth of this square
   eval_t contrib;                             // Signed, white positive
   logic  is_black;

   // Kind lookup; king and empty give zero
   function automatic eval_t piece_value(piece_t p);
      piece_t k;
      k = p & ~PIECE_BLACK;
      case (k)
         PIECE_PAWN:   return VAL_PAWN;
         PIECE_KNIGHT: return VAL_KNIGHT;
         PIECE_BISHOP: return VAL_BISHOP;
         PIECE_ROOK:   return VAL_ROOK;
         PIECE_QUEEN:  return VAL_QUEEN;
         default:      return '0;
      endcase
   endfunction

   assign is_black = |(rd_piece & PIECE_BLACK);
   assign value    = piece_value(rd_piece);
   assign contrib  = is_black ? -value : value; // Black pieces count against

   // Running white minus black over the scan
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         eval <= '0;
      end
      else if (scan_valid)
      begin
         eval <= (scan_first ? eval_t'(0) : eval) + contrib;  // Restart at square 0
      end
   end

endmodule

`default_nettype wire

/* hdl/control.sv */
`timescale 1ns/100ps
`default_nettype none

module control (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  cmd_valid,
   input  vchess_pkg::cmd_t      cmd,
   output logic                  cmd_credit,
   input  logic                  res_credit,
   output logic                  res_valid,
   output vchess_pkg::result_t   res,
   output logic                  clear,
   output logic                  wr_en,
   output vchess_pkg::square_t   wr_square,
   output vchess_pkg::piece_t    wr_piece,
   output logic                  scan_valid,
   output logic                  scan_first,
   output vchess_pkg::square_t   scan_square,
   input  vchess_pkg::bitboard_t white_attacks,
   input  vchess_pkg::bitboard_t black_attacks,
   input  logic                  white_in_check,
   input  logic                  black_in_check,
   input  vchess_pkg::eval_t     eval
);

   import vchess_pkg::*;

   cmd_t                     q_mem [CMD_DEPTH]; // Command queue storage
   logic [CMD_PTR_WIDTH-1:0] q_wr_ptr;
   logic [CMD_PTR_WIDTH-1:0] q_rd_ptr;
   logic [CMD_CNT_WIDTH-1:0] q_count;           // Entries waiting
   logic [RES_CNT_WIDTH-1:0] res_cnt;           // Result credits in hand
   ctrl_state_t              state;
   logic                     settle;            // Last square folded, flags forming
   cmd_t                     head;
   logic                     push;
   logic                     pop;

   assign head = q_mem[q_rd_ptr];
   assign push = cmd_valid;                     // Host never overruns its credits
   assign pop  = (state == IDLE) && (q_count != '0);

   assign cmd_credit = pop;                     // Credit back as the slot frees
   assign clear      = pop && (head.op == CMD_CLEAR);
   assign wr_en      = pop && (head.op == CMD_SET);
   assign wr_square  = head.square;
   assign wr_piece   = head.piece;

   assign scan_valid = (state == SCAN) && !settle;
   assign scan_first = scan_valid && (scan_square == '0);
   assign res_valid  = (state == SEND) && (res_cnt != '0);  // Only with a credit

   always_ff @(posedge clk)
   begin
      if (push)
      begin
         q_mem[q_wr_ptr] <= cmd;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         q_wr_ptr <= '0;
         q_rd_ptr <= '0;
         q_count  <= '0;
         res_cnt  <= RES_CNT_WIDTH'(RES_CREDITS);
      end
      else
      begin
         if (push)
         begin
            q_wr_ptr <= (q_wr_ptr == CMD_PTR_WIDTH'(CMD_DEPTH - 1)) ? '0 : q_wr_ptr + 1'b1;
         end
         if (pop)
         begin
            q_rd_ptr <= (q_rd_ptr == CMD_PTR_WIDTH'(CMD_DEPTH - 1)) ? '0 : q_rd_ptr + 1'b1;
         end
         q_count <= q_count + CMD_CNT_WIDTH'(push) - CMD_CNT_WIDTH'(pop);
         res_cnt <= res_cnt + RES_CNT_WIDTH'(res_credit) - RES_CNT_WIDTH'(res_valid);
      end
   end

   // CLEAR and SET finish on the pop edge, EVAL walks the board
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state       <= IDLE;
         settle      <= 1'b0;
         scan_square <= '0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               if (pop && head.op == CMD_EVAL)
               begin
                  state       <= SCAN;
                  scan_square <= '0;           // Scan always starts at a1
                  settle      <= 1'b0;
               end
            end
            SCAN:
            begin
               if (settle)
               begin
                  state  <= SEND;              // Result latched this edge
                  settle <= 1'b0;
               end
               else if (scan_square == SQ_LAST)
               begin
                  settle <= 1'b1;              // h8 folds in on this edge
               end
               else
               begin
                  scan_square <= scan_square + square_t'(1);
               end
            end
            SEND:
            begin
               if (res_valid)
               begin
                  state <= IDLE;               // Stalls here with no credit
               end
            end
            default:
            begin
               state <= IDLE;
            end
         endcase
      end
   end

   // Masks and sum are final in the settle cycle
   always_ff @(posedge clk)
   begin
      if (state == SCAN && settle)
      begin
         res.white_attacks  <= white_attacks;
         res.black_attacks  <= black_attacks;
         res.white_in_check <= white_in_check;
         res.black_in_check <= black_in_check;
         res.eval           <= eval;
      end
   end

endmodule

`default_nettype wire

/* hdl/vchess_top.sv */
`timescale 1ns/100ps
`default_nettype none

module vchess_top (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                cmd_valid,
   input  vchess_pkg::cmd_t    cmd,
   output logic                cmd_credit,
   output logic                res_valid,
   output vchess_pkg::result_t res,
   input  logic                res_credit
);

   import vchess_pkg::*;

   logic      clear;                           // control to board_store
   logic      wr_en;
   square_t   wr_square;
   piece_t    wr_piece;
   logic      scan_valid;                      // control to scan blocks
   logic      scan_first;
   square_t   scan_square;
   piece_t    rd_piece;                        // Board read of scan_square
   bitboard_t white_attacks;
   bitboard_t black_attacks;
   logic      white_in_check;
   logic      black_in_check;
   eval_t     eval;

   control u_control (
      .clk            (clk),
      .rst_n          (rst_n),
      .cmd_valid      (cmd_valid),
      .cmd            (cmd),
      .cmd_credit     (cmd_credit),
      .res_credit     (res_credit),
      .res_valid      (res_valid),
      .res            (res),
      .clear          (clear),
      .wr_en          (wr_en),
      .wr_square      (wr_square),
      .wr_piece       (wr_piece),
      .scan_valid     (scan_valid),
      .scan_first     (scan_first),
      .scan_square    (scan_square),
      .white_attacks  (white_attacks),
      .black_attacks  (black_attacks),
      .white_in_check (white_in_check),
      .black_in_check (black_in_check),
      .eval           (eval)
   );

   board_store u_board_store (
      .clk         (clk),
      .rst_n       (rst_n),
      .clear       (clear),
      .wr_en       (wr_en),
      .wr_square   (wr_square),
      .wr_piece    (wr_piece),
      .scan_square (scan_square),
      .rd_piece    (rd_piece)
   );

   attack_map u_attack_map (
      .clk            (clk),
      .rst_n          (rst_n),
      .scan_valid     (scan_valid),
      .scan_first     (scan_first),
      .scan_square    (scan_square),
      .rd_piece       (rd_piece),
      .white_attacks  (white_attacks),
      .black_attacks  (black_attacks),
      .white_in_check (white_in_check),
      .black_in_check (black_in_check)
   );

   material_eval u_material_eval (
      .clk        (clk),
      .rst_n      (rst_n),
      .scan_valid (scan_valid),
      .scan_first (scan_first),
      .rd_piece   (rd_piece),
      .eval       (eval)
   );

endmodule

`default_nettype wire

/* verification/vchess_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module vchess_asserts (
   input logic                    clk,
   input logic                    rst_n,
   input logic                    cmd_valid,
   input logic                    cmd_credit,
   input logic                    res_credit,
   input logic                    res_valid,
   input logic                    scan_valid,
   input logic                    scan_first,
   input vchess_pkg::ctrl_state_t state
);

   import vchess_pkg::*;

   int credits_held;                           // Result credits counted at the ports
   int queued;                                 // Commands pushed and not yet credited
   int squares_done;                           // Scan strobes since scan_first

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         credits_held <= RES_CREDITS;
         queued       <= 0;
         squares_done <= 0;
      end
      else
      begin
         credits_held <= credits_held + int'(res_credit) - int'(res_valid);
         queued       <= queued + int'(cmd_valid) - int'(cmd_credit);
         if (scan_valid)
         begin
            squares_done <= scan_first ? 1 : squares_done + 1;
         end
      end
   end

   // A result only leaves against a credit in hand
   result_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
      res_valid |-> (credits_held > 0))
      else $error("res_valid asserted while holding no result credit");

   // Credit goes back only for a command that was actually queued
   credit_needs_entry: assert property (@(posedge clk) disable iff (!rst_n)
      cmd_credit |-> (queued > 0))
      else $error("cmd_credit pulsed with an empty command queue");

   // SEND follows a full scan with no strobe after h8
   send_after_full_scan: assert property (@(posedge clk) disable iff (!rst_n)
      (state == SEND) |-> (squares_done == NUM_SQUARES))
      else $error("FSM in SEND without exactly one full board scan");

endmodule

bind control vchess_asserts u_asserts (
   .clk        (clk),
   .rst_n      (rst_n),
   .cmd_valid  (cmd_valid),
   .cmd_credit (cmd_credit),
   .res_credit (res_credit),
   .res_valid  (res_valid),
   .scan_valid (scan_valid),
   .scan_first (scan_first),
   .state      (state)
);

`default_nettype wire

/* verification/vchess_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module vchess_tb;

   import vchess_pkg::*;

   localparam int EVALS_BUDGETED  = 20;
   localparam int CYCLES_PER_EVAL = 200;
   localparam int TIMEOUT_CYCLES  = EVALS_BUDGETED * CYCLES_PER_EVAL;
   localparam int RANDOM_BOARDS   = 8;         // Evaluations spent on random boards
   localparam int RANDOM_PIECES   = 12;

   logic        clk;
   logic        rst_n;
   logic        cmd_valid;
   cmd_t        cmd;
   logic        cmd_credit;
   logic        res_valid;
   result_t     res;
   logic        res_credit;

   piece_t      ref_board [64];                // Host mirror of the board
   result_t     got_q [$];                     // Results taken off the channel
   result_t     exp_q [$];                     // Model result per CMD_EVAL sent
   result_t     last_res;
   int          host_credits;                  // Command credits held by host
   int          credit_pulses;
   int          cmds_sent;
   int          results_seen;
   bit          auto_return;                   // Hand back a result credit per result
   int          cycle_count = 0;
   int          error_count;
   int unsigned rng_state;

   vchess_top DUT (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_valid  (cmd_valid),
      .cmd        (cmd),
      .cmd_credit (cmd_credit),
      .res_valid  (res_valid),
      .res        (res),
      .res_credit (res_credit)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #5 clk = ~clk;                        // 10 ns period
      end
   end

   always @(posedge clk)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES)
      begin
         $display("timeout: run still busy after %0d cycles", cycle_count);
         $display("ERRORS FOUND");
         $fatal(1, "simulation timed out");
      end
   end

   task automatic fail_run();
      error_count++;
      $display("ERRORS FOUND");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp)
      else
      begin
         $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
         fail_run();
      end
   endtask

   // Seeded LCG returning its upper bits
   function automatic int unsigned lcg_next();
      rng_state = rng_state * 32'd1103515245 + 32'd12345;
      return rng_state >> 16;
   endfunction

   function automatic bitboard_t square_bit(int sq);
      return bitboard_t'(1) << sq;
   endfunction

   // Targets of one piece by rank and file offsets
   function automatic bitboard_t reach(int sq, piece_t p);
      bitboard_t m;
      piece_t    kind;
      int        rank;
      int        file;
      int        ahead;
      bit        hit;
      m     = '0;
      kind  = p & 4'b0111;
      rank  = sq / 8;
      file  = sq % 8;
      ahead = p[3] ? -1 : 1;                   // Black pawns head down the board
      for (int dr = -2; dr <= 2; dr++)
      begin
         for (int df = -2; df <= 2; df++)
         begin
            case (kind)
               PIECE_PAWN:   hit = (dr == ahead) && (df == 1 || df == -1);
               PIECE_KNIGHT: hit = (dr * df == 2) || (dr * df == -2);
               PIECE_KING:   hit = (dr != 0 || df != 0) && dr * dr <= 1 && df * df <= 1;
               default:      hit = 1'b0;       // Sliders hit nothing here
            endcase
            if (hit && rank + dr >= 0 && rank + dr < 8 && file + df >= 0 && file + df < 8)
            begin
               m[(rank + dr) * 8 + file + df] = 1'b1;
            end
         end
      end
      return m;
   endfunction

   function automatic int worth(piece_t p);
      case (p & 4'b0111)
         PIECE_PAWN:                return 100;
         PIECE_KNIGHT, PIECE_BISHOP: return 300;
         PIECE_ROOK:                return 500;
         PIECE_QUEEN:               return 900;
         default:                   return 0;
      endcase
   endfunction

   // Expected result for the mirrored board
   function automatic result_t model_result();
      result_t   r;
      bitboard_t wk;
      bitboard_t bk;
      int        sum;
      r   = '0;
      wk  = '0;
      bk  = '0;
      sum = 0;
      for (int sq = 0; sq < 64; sq++)
      begin
         if (ref_board[sq][3])
         begin
            r.black_attacks = r.black_attacks | reach(sq, ref_board[sq]);
            sum = sum - worth(ref_board[sq]);
            bk[sq] = (ref_board[sq][2:0] == PIECE_KING[2:0]);
         end
         else
         begin
            r.white_attacks = r.white_attacks | reach(sq, ref_board[sq]);
            sum = sum + worth(ref_board[sq]);
            wk[sq] = (ref_board[sq][2:0] == PIECE_KING[2:0]);
         end
      end
      r.white_in_check = |(wk & r.black_attacks);
      r.black_in_check = |(bk & r.white_attacks);
      r.eval = eval_t'(sum);
      return r;
   endfunction

   // Sample outputs mid-cycle and drop one-cycle pulses
   task automatic tick();
      @(negedge clk);
      if (cmd_credit)
      begin
         credit_pulses++;
         host_credits++;
      end
      res_credit = 1'b0;
      if (res_valid)
      begin
         got_q.push_back(res);
         results_seen++;
         res_credit = auto_return;
      end
   endtask

   task automatic send_cmd(input cmd_op_t op, input int sq, input piece_t p);
      while (host_credits == 0)
      begin
         tick();                               // No sending without a credit
      end
      cmd_valid  = 1'b1;
      cmd.op     = op;
      cmd.square = square_t'(sq);
      cmd.piece  = p;
      host_credits--;
      cmds_sent++;
      tick();
      cmd_valid = 1'b0;
      if (op == CMD_CLEAR)
      begin
         for (int i = 0; i < 64; i++)
         begin
            ref_board[i] = PIECE_EMPTY;
         end
      end
      else if (op == CMD_SET)
      begin
         ref_board[sq] = p;
      end
      else if (op == CMD_EVAL)
      begin
         exp_q.push_back(model_result());      // Board as the scan will see it
      end
   endtask

   task automatic compare_next_result();
      result_t got;
      result_t exp;
      while (got_q.size() == 0)
      begin
         tick();
      end
      assert (exp_q.size() != 0)
      else
      begin
         $display("a result arrived with no evaluation outstanding");
         fail_run();
      end
      got      = got_q.pop_front();
      exp      = exp_q.pop_front();
      last_res = got;
      check_value("white_attacks", got.white_attacks, exp.white_attacks);
      check_value("black_attacks", got.black_attacks, exp.black_attacks);
      check_value("white_in_check", 64'(got.white_in_check), 64'(exp.white_in_check));
      check_value("black_in_check", 64'(got.black_in_check), 64'(exp.black_in_check));
      check_value("eval", 64'(got.eval), 64'(exp.eval));
   endtask

   task automatic empty_board_eval();
      int sent_before;
      int pulses_before;
      sent_before   = cmds_sent;
      pulses_before = credit_pulses;
      send_cmd(CMD_CLEAR, 0, PIECE_EMPTY);
      send_cmd(CMD_EVAL, 0, PIECE_EMPTY);
      compare_next_result();
      check_value("white_attacks", last_res.white_attacks, 64'(0));
      check_value("eval", 64'(last_res.eval), 64'(0));
      check_value("cmd_credit pulses", 64'(credit_pulses - pulses_before),
                  64'(cmds_sent - sent_before));  // One pulse per command
   endtask

   task automatic knight_and_king_masks();
      send_cmd(CMD_CLEAR, 0, PIECE_EMPTY);
      send_cmd(CMD_SET, 0, PIECE_KNIGHT);               // White knight a1
      send_cmd(CMD_SET, 63, PIECE_KING | PIECE_BLACK);  // Black king h8
      send_cmd(CMD_EVAL, 0, PIECE_EMPTY);
      compare_next_result();
      check_value("white_attacks", last_res.white_attacks, square_bit(17) | square_bit(10));
      check_value("black_attacks", last_res.black_attacks,
                  square_bit(62) | square_bit(54) | square_bit(55));
      check_value("eval", 64'(last_res.eval), 64'(300));
   endtask

   task automatic pawn_capture_masks();
      send_cmd(CMD_CLEAR, 0, PIECE_EMPTY);
      send_cmd(CMD_SET, 8, PIECE_PAWN);                 // a2
      send_cmd(CMD_SET, 55, PIECE_PAWN | PIECE_BLACK);  // h7
      send_cmd(CMD_EVAL, 0, PIECE_EMPTY);
      compare_next_result();
      check_value("white_attacks", last_res.white_attacks, square_bit(17));
      check_value("black_attacks", last_res.black_attacks, square_bit(46));
      check_value("eval", 64'(last_res.eval), 64'(0));
   endtask

   task automatic king_check_flags();
      send_cmd(CMD_CLEAR, 0, PIECE_EMPTY);
      send_cmd(CMD_SET, 60, PIECE_KING | PIECE_BLACK);  // Black king e8
      send_cmd(CMD_SET, 4, PIECE_KING);                 // White king e1
      send_cmd(CMD_SET, 45, PIECE_KNIGHT);              // Knight f6 hits e8
      send_cmd(CMD_EVAL, 0, PIECE_EMPTY);
      compare_next_result();
      check_value("black_in_check", 64'(last_res.black_in_check), 64'(1));
      check_value("white_in_check", 64'(last_res.white_in_check), 64'(0));
      send_cmd(CMD_SET, 45, PIECE_EMPTY);
      send_cmd(CMD_EVAL, 0, PIECE_EMPTY);
      compare_next_result();
      check_value("black_in_check", 64'(last_res.black_in_check), 64'(0));
   endtask

   task automatic random_board_sweep();
      int     sq;
      piece_t p;
      for (int b = 0; b < RANDOM_BOARDS; b++)
      begin
         send_cmd(CMD_CLEAR, 0, PIECE_EMPTY);
         for (int n = 0; n < RANDOM_PIECES; n++)
         begin
            sq = int'(lcg_next() % 64);
            p  = piece_t'(lcg_next() % 6 + 1);  // Any kind including sliders
            if (lcg_next() % 2 == 1)
            begin
               p = p | PIECE_BLACK;
            end
            send_cmd(CMD_SET, sq, p);
         end
         send_cmd(CMD_EVAL, 0, PIECE_EMPTY);
         compare_next_result();
      end
   endtask

   task automatic result_back_pressure();
      int pulses_held;
      int results_held;
      auto_return = 1'b0;                       // Host sits on result credits
      send_cmd(CMD_CLEAR, 0, PIECE_EMPTY);
      send_cmd(CMD_SET, 28, PIECE_PAWN);
      send_cmd(CMD_SET, 45, PIECE_KNIGHT | PIECE_BLACK);
      send_cmd(CMD_SET, 6, PIECE_KING);
      repeat (3)
      begin
         send_cmd(CMD_EVAL, 0, PIECE_EMPTY);
      end
      send_cmd(cmd_op_t'(3), 0, PIECE_EMPTY);   // No-ops fill the queue
      send_cmd(cmd_op_t'(3), 0, PIECE_EMPTY);
      compare_next_result();
      compare_next_result();
      pulses_held  = credit_pulses;
      results_held = results_seen;
      repeat (CYCLES_PER_EVAL)
      begin
         tick();
      end
      check_value("res_valid count", 64'(results_seen), 64'(results_held));
      check_value("cmd_credit pulses", 64'(credit_pulses), 64'(pulses_held));
      check_value("host credits", 64'(host_credits), 64'(0));
      res_credit = 1'b1;                        // Release the third result
      tick();
      compare_next_result();
      while (host_credits < CMD_DEPTH)
      begin
         tick();                                // No-ops drain behind it
      end
      res_credit = 1'b1;
      tick();
      res_credit = 1'b1;
      tick();
      auto_return = 1'b1;
   endtask

   initial
   begin
      rst_n         = 1'b0;
      cmd_valid     = 1'b0;
      cmd           = '0;
      res_credit    = 1'b0;
      host_credits  = CMD_DEPTH;
      credit_pulses = 0;
      cmds_sent     = 0;
      results_seen  = 0;
      auto_return   = 1'b1;
      error_count   = 0;
      rng_state     = 4;
      for (int i = 0; i < 64; i++)
      begin
         ref_board[i] = PIECE_EMPTY;
      end
      repeat (4) @(posedge clk);                // Reset over 4 rising edges
      @(negedge clk);
      rst_n = 1'b1;
      empty_board_eval();
      knight_and_king_masks();
      pawn_capture_masks();
      king_check_flags();
      random_board_sweep();
      result_back_pressure();
      if (error_count == 0)
      begin
         $display("NO ERRORS");
      end
      else
      begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sources.f */
hdl/vchess_pkg.sv
hdl/board_store.sv
hdl/attack_map.sv
hdl/material_eval.sv
hdl/control.sv
hdl/vchess_top.sv
verification/vchess_asserts.sv
verification/vchess_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build vchess_tb with Verilator, run it, and judge the run from sim.log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module vchess_tb -f sources.f -o vchess_sim \
   || { echo "Verilator build failed"; exit 1; }

# A crash or a nonzero exit from an assertion also counts as a failure
./obj_dir/vchess_sim > sim.log 2>&1 || echo "ERRORS FOUND" >> sim.log
cat sim.log

grep -q "ERRORS FOUND" sim.log && { echo "Simulation failed"; exit 1; } \
   || { echo "Simulation passed"; exit 0; }
